// File: source/conv_pkg.sv
`default_nettype none

package conv_pkg;

    // Bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // Kernel geometry
    localparam int WT_DIM  = 3;
    localparam int WT_TAPS = WT_DIM * WT_DIM;

    // Byte step between consecutive words
    localparam int WORD_BYTES = 4;

    // Counter widths and terminal counts
    localparam int TAP_W  = $clog2(WT_TAPS);
    localparam int KROW_W = $clog2(WT_DIM);
    localparam logic [TAP_W-1:0]  LAST_TAP  = TAP_W'(WT_TAPS - 1);
    localparam logic [KROW_W-1:0] LAST_KROW = KROW_W'(WT_DIM - 1);

    // Run configuration, captured when a run starts
    typedef struct packed {
        logic [31:0] fm_dim;
        logic [31:0] wt_offset;
        logic [31:0] ifm_offset;
        logic [31:0] ofm_offset;
    } conv_cfg_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [31:0]       len;
    } rd_req_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
    } wr_req_t;

endpackage

`default_nettype wire

// File: source/conv_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module conv_ctrl (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                start,
    input  wire conv_pkg::conv_cfg_t cfg,
    input  wire logic                rd_req_ready,
    input  wire logic                wr_ack,
    output conv_pkg::rd_req_t        rd_req,
    output logic                     rd_req_valid,
    output logic                     run_start,
    output logic                     busy
);

    logic [31:0]                   out_dim;
    logic [31:0]                   out_total;
    logic [31:0]                   col;
    logic [31:0]                   row;
    logic [31:0]                   ack_cnt;
    logic [31:0]                   pix_word;
    logic [conv_pkg::KROW_W-1:0]   krow;
    logic                          issuing;
    logic                          wt_pending;
    logic                          req_fire;

    // Valid-mode output side and pixel count
    assign out_dim   = cfg.fm_dim - 32'(conv_pkg::WT_DIM - 1);
    assign out_total = out_dim * out_dim;

    assign run_start    = start && !busy;
    assign rd_req_valid = issuing;
    assign req_fire     = rd_req_valid && rd_req_ready;

    // Word index of the first tap in the current kernel row
    assign pix_word = (row + 32'(krow)) * cfg.fm_dim + col;

    always_comb begin
        if (wt_pending) begin
            rd_req.addr = cfg.wt_offset;
            rd_req.len  = 32'(conv_pkg::WT_TAPS);
        end else begin
            rd_req.addr = cfg.ifm_offset + pix_word * conv_pkg::WORD_BYTES;
            rd_req.len  = 32'(conv_pkg::WT_DIM);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy       <= 1'b0;
            issuing    <= 1'b0;
            wt_pending <= 1'b0;
            col        <= '0;
            row        <= '0;
            krow       <= '0;
            ack_cnt    <= '0;
        end else begin
            if (run_start) begin
                busy       <= 1'b1;
                issuing    <= 1'b1;
                wt_pending <= 1'b1;
                col        <= '0;
                row        <= '0;
                krow       <= '0;
                ack_cnt    <= '0;
            end
            // Weight burst first, then kernel rows of each output pixel
            if (req_fire) begin
                if (wt_pending) begin
                    wt_pending <= 1'b0;
                end else if (krow != conv_pkg::LAST_KROW) begin
                    krow <= krow + 1'b1;
                end else begin
                    krow <= '0;
                    if (col != out_dim - 32'd1) begin
                        col <= col + 32'd1;
                    end else begin
                        col <= '0;
                        if (row != out_dim - 32'd1) begin
                            row <= row + 32'd1;
                        end else begin
                            issuing <= 1'b0;
                        end
                    end
                end
            end
            // Run ends once every output has its write status
            if (wr_ack) begin
                ack_cnt <= ack_cnt + 32'd1;
                if (ack_cnt == out_total - 32'd1) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    a_req_hold: assert property (@(posedge clk) disable iff (rst)
        rd_req_valid && !rd_req_ready |=> rd_req_valid && $stable(rd_req));

endmodule

`default_nettype wire

// File: source/conv_mac.sv
`timescale 1ns/1ps
`default_nettype none

module conv_mac (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          run_start,
    input  wire logic [conv_pkg::DATA_W-1:0]   rdata,
    input  wire logic                          rdata_valid,
    input  wire logic                          res_ready,
    output logic                               rdata_ready,
    output logic                               res_valid,
    output logic [conv_pkg::DATA_W-1:0]        res
);

    logic [conv_pkg::DATA_W-1:0] wt_bank [conv_pkg::WT_TAPS];
    logic [conv_pkg::DATA_W-1:0] acc;
    logic [conv_pkg::DATA_W-1:0] prod;
    logic [conv_pkg::TAP_W-1:0]  tap;
    logic                        wt_loaded;
    logic                        armed;
    logic                        beat_fire;

    // Stall read data while a finished result cannot leave
    assign rdata_ready = armed && (!res_valid || res_ready);
    assign beat_fire   = rdata_valid && rdata_ready;
    assign prod        = rdata * wt_bank[tap];

    always_ff @(posedge clk) begin
        if (beat_fire && !wt_loaded) begin
            wt_bank[tap] <= rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (beat_fire && wt_loaded && tap == conv_pkg::LAST_TAP) begin
            res <= acc + prod;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            armed     <= 1'b0;
            wt_loaded <= 1'b0;
            tap       <= '0;
            acc       <= '0;
            res_valid <= 1'b0;
        end else if (run_start) begin
            armed     <= 1'b1;
            wt_loaded <= 1'b0;
            tap       <= '0;
            acc       <= '0;
            res_valid <= 1'b0;
        end else begin
            if (res_valid && res_ready) begin
                res_valid <= 1'b0;
            end
            if (beat_fire) begin
                if (tap == conv_pkg::LAST_TAP) begin
                    tap <= '0;
                    acc <= '0;
                    // First group of a run is the weight block
                    if (wt_loaded) begin
                        res_valid <= 1'b1;
                    end else begin
                        wt_loaded <= 1'b1;
                    end
                end else begin
                    tap <= tap + 1'b1;
                    if (wt_loaded) begin
                        acc <= acc + prod;
                    end
                end
            end
        end
    end

    a_res_hold: assert property (@(posedge clk) disable iff (rst)
        res_valid && !res_ready |=> res_valid && $stable(res));

endmodule

`default_nettype wire

// File: source/conv_write_port.sv
`timescale 1ns/1ps
`default_nettype none

module conv_write_port (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          run_start,
    input  wire conv_pkg::conv_cfg_t           cfg,
    input  wire logic                          res_valid,
    input  wire logic [conv_pkg::DATA_W-1:0]   res,
    input  wire logic                          wr_addr_ready,
    input  wire logic                          wr_data_ready,
    input  wire logic                          wr_status_valid,
    output logic                               res_ready,
    output conv_pkg::wr_req_t                  wr_req,
    output logic                               wr_addr_valid,
    output logic                               wr_data_valid,
    output logic                               wr_status_ready,
    output logic                               wr_ack
);

    logic [conv_pkg::DATA_W-1:0] buf_data;
    logic [31:0]                 out_idx;
    logic                        buf_full;
    logic                        res_fire;
    logic                        status_fire;

    // Buffer stays occupied until the write status returns
    assign res_ready       = !buf_full;
    assign res_fire        = res_valid && res_ready;
    assign wr_status_ready = buf_full;
    assign status_fire     = wr_status_valid && wr_status_ready;
    assign wr_ack          = status_fire;

    assign wr_req.addr = cfg.ofm_offset + out_idx * conv_pkg::WORD_BYTES;
    assign wr_req.data = buf_data;

    always_ff @(posedge clk) begin
        if (res_fire) begin
            buf_data <= res;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || run_start) begin
            buf_full      <= 1'b0;
            wr_addr_valid <= 1'b0;
            wr_data_valid <= 1'b0;
            out_idx       <= '0;
        end else begin
            if (res_fire) begin
                buf_full      <= 1'b1;
                wr_addr_valid <= 1'b1;
                wr_data_valid <= 1'b1;
            end
            // Address and data channels accept independently
            if (wr_addr_valid && wr_addr_ready) begin
                wr_addr_valid <= 1'b0;
            end
            if (wr_data_valid && wr_data_ready) begin
                wr_data_valid <= 1'b0;
            end
            if (status_fire) begin
                buf_full <= 1'b0;
                out_idx  <= out_idx + 32'd1;
            end
        end
    end

    // Status only after both address and data were taken by memory
    a_status_after_write: assert property (@(posedge clk) disable iff (rst)
        status_fire |-> !wr_addr_valid && !wr_data_valid);

endmodule

`default_nettype wire

// File: source/conv2d_opt.sv
`timescale 1ns/1ps
`default_nettype none

module conv2d_opt (
    input  wire logic                          clk,
    input  wire logic                          rst,

    input  wire logic                          start,
    output logic                               idle,
    output logic                               done,

    input  wire logic [31:0]                   fm_dim,
    input  wire logic [31:0]                   wt_offset,
    input  wire logic [31:0]                   ifm_offset,
    input  wire logic [31:0]                   ofm_offset,

    output logic [conv_pkg::ADDR_W-1:0]        req_read_addr,
    output logic                               req_read_addr_valid,
    input  wire logic                          req_read_addr_ready,
    output logic [31:0]                        req_read_len,

    input  wire logic [conv_pkg::DATA_W-1:0]   resp_read_data,
    input  wire logic                          resp_read_data_valid,
    output logic                               resp_read_data_ready,

    output logic [conv_pkg::ADDR_W-1:0]        req_write_addr,
    output logic                               req_write_addr_valid,
    input  wire logic                          req_write_addr_ready,
    output logic [31:0]                        req_write_len,

    output logic [conv_pkg::DATA_W-1:0]        req_write_data,
    output logic                               req_write_data_valid,
    input  wire logic                          req_write_data_ready,

    input  wire logic                          resp_write_status,
    input  wire logic                          resp_write_status_valid,
    output logic                               resp_write_status_ready
);

    conv_pkg::conv_cfg_t         cfg_q;
    conv_pkg::rd_req_t           rd_req;
    conv_pkg::wr_req_t           wr_req;
    logic [conv_pkg::DATA_W-1:0] res;
    logic                        run_start;
    logic                        busy;
    logic                        busy_q;
    logic                        wr_ack;
    logic                        res_valid;
    logic                        res_ready;

    // Scalars captured on an accepted start
    always_ff @(posedge clk) begin
        if (run_start) begin
            cfg_q.fm_dim     <= fm_dim;
            cfg_q.wt_offset  <= wt_offset;
            cfg_q.ifm_offset <= ifm_offset;
            cfg_q.ofm_offset <= ofm_offset;
        end
    end

    // Done follows the falling edge of busy by one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q <= 1'b0;
            done   <= 1'b0;
        end else begin
            busy_q <= busy;
            if (run_start) begin
                done <= 1'b0;
            end else if (busy_q && !busy) begin
                done <= 1'b1;
            end
        end
    end

    assign idle          = !busy;
    assign req_read_addr = rd_req.addr;
    assign req_read_len  = rd_req.len;

    // Every output word goes out as a single-beat write
    assign req_write_len  = 32'd1;
    assign req_write_addr = wr_req.addr;
    assign req_write_data = wr_req.data;

    conv_ctrl ctrl_i (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .cfg          (cfg_q),
        .rd_req_ready (req_read_addr_ready),
        .wr_ack       (wr_ack),
        .rd_req       (rd_req),
        .rd_req_valid (req_read_addr_valid),
        .run_start    (run_start),
        .busy         (busy)
    );

    conv_mac mac_i (
        .clk         (clk),
        .rst         (rst),
        .run_start   (run_start),
        .rdata       (resp_read_data),
        .rdata_valid (resp_read_data_valid),
        .res_ready   (res_ready),
        .rdata_ready (resp_read_data_ready),
        .res_valid   (res_valid),
        .res         (res)
    );

    conv_write_port wr_port_i (
        .clk             (clk),
        .rst             (rst),
        .run_start       (run_start),
        .cfg             (cfg_q),
        .res_valid       (res_valid),
        .res             (res),
        .wr_addr_ready   (req_write_addr_ready),
        .wr_data_ready   (req_write_data_ready),
        .wr_status_valid (resp_write_status_valid),
        .res_ready       (res_ready),
        .wr_req          (wr_req),
        .wr_addr_valid   (req_write_addr_valid),
        .wr_data_valid   (req_write_data_valid),
        .wr_status_ready (resp_write_status_ready),
        .wr_ack          (wr_ack)
    );

endmodule

`default_nettype wire

// File: dv/conv_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module conv_mem_model (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic [4:0]  stall,
    input  wire logic        load_en,
    input  wire logic [8:0]  load_addr,
    input  wire logic [31:0] load_data,
    input  wire logic [31:0] req_read_addr,
    input  wire logic        req_read_addr_valid,
    output logic             req_read_addr_ready,
    input  wire logic [31:0] req_read_len,
    output logic [31:0]      resp_read_data,
    output logic             resp_read_data_valid,
    input  wire logic        resp_read_data_ready,
    input  wire logic [31:0] req_write_addr,
    input  wire logic        req_write_addr_valid,
    output logic             req_write_addr_ready,
    input  wire logic [31:0] req_write_data,
    input  wire logic        req_write_data_valid,
    output logic             req_write_data_ready,
    output logic             resp_write_status,
    output logic             resp_write_status_valid,
    input  wire logic        resp_write_status_ready
);

    // 512 words selected by byte address bits [10:2]
    logic [31:0] mem [0:511];
    logic [31:0] log_addr [0:255];
    int unsigned wr_count;
    int unsigned stat_count;

    logic [31:0] burst_addr [$];
    logic [31:0] burst_len [$];
    logic [31:0] beat_addr;
    logic [31:0] beat_left;
    logic [31:0] wr_addr;
    logic [31:0] wr_data;
    logic        have_addr;
    logic        have_data;
    logic        status_due;
    logic        rv;
    logic        sv;

    always @(posedge clk) begin
        if (rst) begin
            req_read_addr_ready     <= 1'b0;
            resp_read_data          <= '0;
            resp_read_data_valid    <= 1'b0;
            req_write_addr_ready    <= 1'b0;
            req_write_data_ready    <= 1'b0;
            resp_write_status       <= 1'b0;
            resp_write_status_valid <= 1'b0;
            beat_addr = '0;
            beat_left = '0;
            have_addr = 1'b0;
            have_data = 1'b0;
            status_due = 1'b0;
            wr_count = 0;
            stat_count = 0;
            burst_addr.delete();
            burst_len.delete();
        end else begin
            if (load_en) begin
                mem[load_addr] <= load_data;
            end
            // Read bursts are served strictly in request order
            if (req_read_addr_valid && req_read_addr_ready) begin
                burst_addr.push_back(req_read_addr);
                burst_len.push_back(req_read_len);
            end
            req_read_addr_ready <= !stall[0];
            rv = resp_read_data_valid;
            if (rv && resp_read_data_ready) begin
                rv = 1'b0;
                beat_addr = beat_addr + 32'd4;
                beat_left = beat_left - 32'd1;
            end
            if (beat_left == 32'd0 && burst_addr.size() > 0) begin
                beat_addr = burst_addr.pop_front();
                beat_left = burst_len.pop_front();
            end
            if (!rv && beat_left != 32'd0 && !stall[1]) begin
                resp_read_data <= mem[beat_addr[10:2]];
                rv = 1'b1;
            end
            resp_read_data_valid <= rv;
            // Address and data may arrive on different cycles
            if (req_write_addr_valid && req_write_addr_ready) begin
                wr_addr = req_write_addr;
                have_addr = 1'b1;
            end
            if (req_write_data_valid && req_write_data_ready) begin
                wr_data = req_write_data;
                have_data = 1'b1;
            end
            if (have_addr && have_data) begin
                mem[wr_addr[10:2]] <= wr_data;
                log_addr[wr_count[7:0]] <= wr_addr;
                wr_count = wr_count + 1;
                have_addr = 1'b0;
                have_data = 1'b0;
                status_due = 1'b1;
            end
            req_write_addr_ready <= !stall[2];
            req_write_data_ready <= !stall[3];
            sv = resp_write_status_valid;
            if (sv && resp_write_status_ready) begin
                sv = 1'b0;
                stat_count = stat_count + 1;
            end
            if (!sv && status_due && !stall[4]) begin
                sv = 1'b1;
                status_due = 1'b0;
            end
            resp_write_status_valid <= sv;
            resp_write_status       <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: dv/conv_tb.sv
`timescale 1ns/1ps
`default_nettype none

module conv_tb;

    logic                clk;
    logic                rst;
    logic                start;
    logic                idle;
    logic                done;
    conv_pkg::conv_cfg_t cfg;
    logic [4:0]          stall;
    logic                load_en;
    logic [8:0]          load_addr;
    logic [31:0]         load_data;
    logic [31:0]         lfsr;

    logic [31:0] rd_addr;
    logic        rd_addr_valid;
    logic        rd_addr_ready;
    logic [31:0] rd_len;
    logic [31:0] rd_data;
    logic        rd_data_valid;
    logic        rd_data_ready;
    logic [31:0] wr_addr;
    logic        wr_addr_valid;
    logic        wr_addr_ready;
    logic [31:0] wr_len;
    logic [31:0] wr_data;
    logic        wr_data_valid;
    logic        wr_data_ready;
    logic        wr_status;
    logic        wr_status_valid;
    logic        wr_status_ready;

    // Memory image as the host sees it, and after the expected writes
    logic [31:0] image [0:511];
    logic [31:0] exp_mem [0:511];

    conv2d_opt dut_i (
        .clk                     (clk),
        .rst                     (rst),
        .start                   (start),
        .idle                    (idle),
        .done                    (done),
        .fm_dim                  (cfg.fm_dim),
        .wt_offset               (cfg.wt_offset),
        .ifm_offset              (cfg.ifm_offset),
        .ofm_offset              (cfg.ofm_offset),
        .req_read_addr           (rd_addr),
        .req_read_addr_valid     (rd_addr_valid),
        .req_read_addr_ready     (rd_addr_ready),
        .req_read_len            (rd_len),
        .resp_read_data          (rd_data),
        .resp_read_data_valid    (rd_data_valid),
        .resp_read_data_ready    (rd_data_ready),
        .req_write_addr          (wr_addr),
        .req_write_addr_valid    (wr_addr_valid),
        .req_write_addr_ready    (wr_addr_ready),
        .req_write_len           (wr_len),
        .req_write_data          (wr_data),
        .req_write_data_valid    (wr_data_valid),
        .req_write_data_ready    (wr_data_ready),
        .resp_write_status       (wr_status),
        .resp_write_status_valid (wr_status_valid),
        .resp_write_status_ready (wr_status_ready)
    );

    conv_mem_model mem_i (
        .clk                     (clk),
        .rst                     (rst),
        .stall                   (stall),
        .load_en                 (load_en),
        .load_addr               (load_addr),
        .load_data               (load_data),
        .req_read_addr           (rd_addr),
        .req_read_addr_valid     (rd_addr_valid),
        .req_read_addr_ready     (rd_addr_ready),
        .req_read_len            (rd_len),
        .resp_read_data          (rd_data),
        .resp_read_data_valid    (rd_data_valid),
        .resp_read_data_ready    (rd_data_ready),
        .req_write_addr          (wr_addr),
        .req_write_addr_valid    (wr_addr_valid),
        .req_write_addr_ready    (wr_addr_ready),
        .req_write_data          (wr_data),
        .req_write_data_valid    (wr_data_valid),
        .req_write_data_ready    (wr_data_ready),
        .resp_write_status       (wr_status),
        .resp_write_status_valid (wr_status_valid),
        .resp_write_status_ready (wr_status_ready)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] bits);
        int k;
        bits = '0;
        for (k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            bits = {bits[30:0], lfsr[0]};
        end
    endtask

    // One clock, then fresh stall bits for all five channels
    task automatic tick();
        logic [31:0] bits;
        @(posedge clk);
        #1;
        take_bits(5, bits);
        stall = bits[4:0];
    endtask

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic fill_memory();
        logic [31:0] bits;
        int k;
        load_en = 1'b1;
        for (k = 0; k < 512; k++) begin
            take_bits(32, bits);
            image[k] = bits;
            load_addr = 9'(k);
            load_data = bits;
            tick();
        end
        load_en = 1'b0;
    endtask

    task automatic run_conv(input conv_pkg::conv_cfg_t c);
        int fm;
        int od;
        int r;
        int col;
        int i;
        int j;
        int k;
        int cycles;
        int wr0;
        int st0;
        int wt_w;
        int ifm_w;
        int ofm_w;
        logic [31:0] sum;
        logic [31:0] a;
        logic        in_region;
        fm = int'(c.fm_dim);
        od = fm - conv_pkg::WT_DIM + 1;
        wt_w = int'(c.wt_offset) / 4;
        ifm_w = int'(c.ifm_offset) / 4;
        ofm_w = int'(c.ofm_offset) / 4;
        // Reference valid-mode convolution over the host image
        for (k = 0; k < 512; k++) begin
            exp_mem[k] = image[k];
        end
        for (r = 0; r < od; r++) begin
            for (col = 0; col < od; col++) begin
                sum = '0;
                for (i = 0; i < conv_pkg::WT_DIM; i++) begin
                    for (j = 0; j < conv_pkg::WT_DIM; j++) begin
                        sum = sum + image[ifm_w + (r + i) * fm + col + j]
                            * image[wt_w + i * conv_pkg::WT_DIM + j];
                    end
                end
                exp_mem[ofm_w + r * od + col] = sum;
            end
        end
        wr0 = int'(mem_i.wr_count);
        st0 = int'(mem_i.stat_count);
        check_eq(32'(idle), 32'd1, "idle before start");
        cfg = c;
        start = 1'b1;
        tick();
        start = 1'b0;
        check_eq(32'(idle), 32'd0, "idle after accepted start");
        check_eq(32'(done), 32'd0, "done after accepted start");
        cycles = 0;
        while (!done) begin
            if (cycles >= 20000) begin
                $display("Timed out waiting for done at %0t ns", $time);
                $display("RESULT: FAIL");
                $fatal(1, "done never rose");
            end
            if (idle) begin
                check_eq(32'(int'(mem_i.stat_count) - st0), 32'(od * od), "status count at idle");
            end
            tick();
            cycles++;
        end
        check_eq(32'(idle), 32'd1, "idle with done");
        check_eq(32'(int'(mem_i.stat_count) - st0), 32'(od * od), "write status count");
        check_eq(32'(int'(mem_i.wr_count) - wr0), 32'(od * od), "write count");
        for (k = wr0; k < wr0 + od * od; k++) begin
            a = mem_i.log_addr[k % 256];
            in_region = a >= c.ofm_offset && a < c.ofm_offset + 32'(4 * od * od)
                && a[1:0] == 2'b00;
            check_eq(32'(in_region), 32'd1, $sformatf("write address %h in output region", a));
        end
        for (k = 0; k < 512; k++) begin
            check_eq(mem_i.mem[k], exp_mem[k], $sformatf("memory word %0d", k));
        end
    endtask

    initial begin
        conv_pkg::conv_cfg_t c;
        logic [31:0] bits;
        int run;
        lfsr = 32'h38576a63;
        rst = 1'b1;
        start = 1'b0;
        cfg = '0;
        stall = '0;
        load_en = 1'b0;
        load_addr = '0;
        load_data = '0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        check_eq(32'(idle), 32'd1, "idle after reset");
        check_eq(32'(done), 32'd0, "done after reset");
        check_eq(32'(rd_addr_valid), 32'd0, "read request valid after reset");
        check_eq(32'(rd_data_ready), 32'd0, "read data ready after reset");
        check_eq(32'(wr_addr_valid), 32'd0, "write address valid after reset");
        check_eq(32'(wr_data_valid), 32'd0, "write data valid after reset");
        check_eq(32'(wr_status_ready), 32'd0, "write status ready after reset");
        for (run = 0; run < 4; run++) begin
            fill_memory();
            if (run > 0) begin
                check_eq(32'(done), 32'd1, "done held until the next start");
            end
            // First run uses the smallest map with a single output
            take_bits(2, bits);
            c.fm_dim = (run == 0) ? 32'd3 : 32'd3 + bits;
            take_bits(6, bits);
            c.wt_offset = bits * 4;
            take_bits(6, bits);
            c.ifm_offset = (32'd128 + bits) * 4;
            take_bits(7, bits);
            c.ofm_offset = (32'd256 + bits) * 4;
            run_conv(c);
        end
        check_eq(wr_len, 32'd1, "write length");
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
source/conv_pkg.sv
source/conv_ctrl.sv
source/conv_mac.sv
source/conv_write_port.sv
source/conv2d_opt.sv
dv/conv_mem_model.sv
dv/conv_tb.sv

// File: Makefile
all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module conv_tb -Mdir obj_dir

run: compile
	./obj_dir/Vconv_tb 2>&1 | tee sim.log
	@if grep -q "RESULT: FAIL" sim.log; then exit 1; fi
	@grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean
